// ==== design/sr_conv_macros.svh ====
`ifndef SR_CONV_MACROS_SVH
`define SR_CONV_MACROS_SVH

// Pixel channel width, unsigned
`define SR_CHAN_W 8

// Input and output channel count (RGB)
`define SR_CHANNELS 3

`define SR_TAPS 9           // 3x3 kernel
`define SR_KPOS_W 4         // Kernel position and window address width
`define SR_STEPS 27         // Taps times input channels

// 81 weights, then one bias per output channel at 81..83
`define SR_WEIGHTS 81
`define SR_COEF_ADDR_W 7

// 27 products of 9x8 bits plus a bias reach about 2^19.75, sign included
`define SR_ACC_W 21

`endif

// ==== design/sr_conv_pkg.sv ====
`include "sr_conv_macros.svh"

package sr_conv_pkg;

    // One colour channel
    typedef logic [`SR_CHAN_W-1:0] chan_t;

    // Weight or bias
    typedef logic signed [`SR_CHAN_W-1:0] coef_t;

    typedef logic [`SR_COEF_ADDR_W-1:0] coef_addr_t;

    // Channel 0 is r, 1 is g, 2 is b
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    // One accumulate step, sequencer to stores and MAC array
    typedef struct packed {
        logic                  valid;
        logic                  first;   // Clears the accumulators
        logic                  last;    // Triggers the finish stage
        logic [1:0]            in_chan;
        logic [`SR_KPOS_W-1:0] kpos;    // Row-major window position
    } tap_t;

    typedef enum logic {
        IDLE,
        ACCUM
    } seq_state_e;

endpackage

// ==== design/conv_sequencer.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module conv_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output sr_conv_pkg::tap_t tap,
    output logic              busy
);
    import sr_conv_pkg::*;

    localparam int LAST_KPOS = `SR_TAPS - 1;
    localparam int LAST_CHAN = `SR_CHANNELS - 1;

    seq_state_e            state;
    logic [1:0]            next_chan;
    logic [`SR_KPOS_W-1:0] next_kpos;
    logic                  next_last;

    // Kernel position runs fastest, then input channel
    always_comb begin
        if (tap.kpos == LAST_KPOS[`SR_KPOS_W-1:0]) begin
            next_kpos = '0;
            next_chan = tap.in_chan + 2'd1;
        end else begin
            next_kpos = tap.kpos + 1'b1;
            next_chan = tap.in_chan;
        end
        next_last = (next_chan == LAST_CHAN[1:0]) && (next_kpos == LAST_KPOS[`SR_KPOS_W-1:0]);
    end

    // Busy also covers the accept cycle
    assign busy = start || (state == ACCUM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            tap   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ACCUM;
                        tap   <= '{valid: 1'b1, first: 1'b1, last: 1'b0, in_chan: 2'd0, kpos: '0};
                    end
                end
                ACCUM: begin
                    if (tap.last) begin
                        state <= IDLE;
                        tap   <= '0;             // Back to an idle bubble
                    end else begin
                        tap.first   <= 1'b0;
                        tap.last    <= next_last;
                        tap.in_chan <= next_chan;
                        tap.kpos    <= next_kpos;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/kernel_store.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module kernel_store (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  busy,
    input  logic                                  coef_we,
    input  sr_conv_pkg::coef_addr_t               coef_addr,
    input  sr_conv_pkg::coef_t                    coef_data,
    input  sr_conv_pkg::tap_t                     tap,
    output sr_conv_pkg::coef_t [`SR_CHANNELS-1:0] weights,
    output sr_conv_pkg::coef_t [`SR_CHANNELS-1:0] biases
);
    import sr_conv_pkg::*;

    // Address stride between output channels
    localparam int OC_STRIDE = `SR_CHANNELS * `SR_TAPS;

    coef_t w_mem [`SR_WEIGHTS];
    coef_t b_mem [`SR_CHANNELS];
    int    base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SR_WEIGHTS; i++) begin
                w_mem[i] <= '0;
            end
            for (int i = 0; i < `SR_CHANNELS; i++) begin
                b_mem[i] <= '0;
            end
        end else if (coef_we && !busy) begin
            if (coef_addr < `SR_WEIGHTS) begin
                w_mem[coef_addr] <= coef_data;
            end else if (coef_addr < `SR_WEIGHTS + `SR_CHANNELS) begin
                b_mem[coef_addr - `SR_WEIGHTS] <= coef_data;
            end
            // Anything above the biases falls through
        end
    end

    // One weight per output channel for the current tap
    always_comb begin
        base = int'(tap.in_chan) * `SR_TAPS + int'(tap.kpos);
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            weights[oc] = w_mem[oc * OC_STRIDE + base];
            biases[oc]  = b_mem[oc];
        end
    end

endmodule

// ==== design/window_buffer.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module window_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic                  pix_we,
    input  logic [`SR_KPOS_W-1:0] pix_addr,
    input  sr_conv_pkg::pixel_t   pix_data,
    input  sr_conv_pkg::tap_t     tap,
    output sr_conv_pkg::chan_t    operand
);
    import sr_conv_pkg::*;

    pixel_t win [`SR_TAPS];     // Row-major 3x3
    pixel_t sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SR_TAPS; i++) begin
                win[i] <= '0;
            end
        end else if (pix_we && !busy && (pix_addr < `SR_TAPS)) begin
            win[pix_addr] <= pix_data;
        end
    end

    assign sel = win[tap.kpos];

    // Channel pick for this tap
    always_comb begin
        case (tap.in_chan)
            2'd0:    operand = sel.r;
            2'd1:    operand = sel.g;
            default: operand = sel.b;
        endcase
    end

endmodule

// ==== design/mac_array.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module mac_array (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  sr_conv_pkg::tap_t                     tap,
    input  sr_conv_pkg::chan_t                    operand,
    input  sr_conv_pkg::coef_t [`SR_CHANNELS-1:0] weights,
    input  sr_conv_pkg::coef_t [`SR_CHANNELS-1:0] biases,
    output sr_conv_pkg::pixel_t                   pixel_out,
    output logic                                  done
);
    import sr_conv_pkg::*;

    localparam int PROD_W  = 2 * `SR_CHAN_W + 1;      // 9-bit unsigned-as-signed x 8-bit
    localparam int MAX_VAL = (1 << `SR_CHAN_W) - 1;
    localparam logic signed [`SR_ACC_W-1:0] ACC_ZERO = '0;

    logic signed [PROD_W-1:0]    prod     [`SR_CHANNELS];
    logic signed [`SR_ACC_W-1:0] acc      [`SR_CHANNELS];
    logic signed [`SR_ACC_W-1:0] acc_next [`SR_CHANNELS];
    logic signed [`SR_ACC_W-1:0] fin_sum  [`SR_CHANNELS];  // Held for the finish stage
    logic                        fin_pending;
    chan_t                       clamped  [`SR_CHANNELS];

    always_comb begin
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            prod[oc]     = $signed({1'b0, operand}) * $signed(weights[oc]);
            // First tap loads the product
            acc_next[oc] = (tap.first ? ACC_ZERO : acc[oc]) + prod[oc];
        end
    end

    always_ff @(posedge clk) begin
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            if (tap.valid) begin
                acc[oc] <= acc_next[oc];
            end
            if (tap.valid && tap.last) begin
                fin_sum[oc] <= acc_next[oc] + $signed(biases[oc]);
            end
        end
    end

    // Clamp to pixel range, covers ReLU too
    always_comb begin
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            if (fin_sum[oc] < 0) begin
                clamped[oc] = '0;
            end else if (fin_sum[oc] > MAX_VAL) begin
                clamped[oc] = '1;
            end else begin
                clamped[oc] = fin_sum[oc][`SR_CHAN_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fin_pending <= 1'b0;
            done        <= 1'b0;
            pixel_out   <= '0;
        end else begin
            fin_pending <= tap.valid && tap.last;
            done        <= fin_pending;
            if (fin_pending) begin
                pixel_out <= '{r: clamped[0], g: clamped[1], b: clamped[2]};
            end
        end
    end

endmodule

// ==== design/sr_conv_top.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module sr_conv_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // Coefficient write port
    input  logic                    coef_we,
    input  sr_conv_pkg::coef_addr_t coef_addr,
    input  sr_conv_pkg::coef_t      coef_data,
    // Window write port
    input  logic                    pix_we,
    input  logic [`SR_KPOS_W-1:0]   pix_addr,
    input  sr_conv_pkg::pixel_t     pix_data,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output sr_conv_pkg::pixel_t     pixel_out
);
    import sr_conv_pkg::*;

    tap_t                     tap;
    coef_t [`SR_CHANNELS-1:0] weights;
    coef_t [`SR_CHANNELS-1:0] biases;
    chan_t                    operand;

    conv_sequencer seq0 (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .tap   (tap),
        .busy  (busy)
    );

    kernel_store kstore0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .busy      (busy),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .tap       (tap),
        .weights   (weights),
        .biases    (biases)
    );

    window_buffer wbuf0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy     (busy),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .tap      (tap),
        .operand  (operand)
    );

    // One multiplier per output channel
    mac_array mac0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .tap       (tap),
        .operand   (operand),
        .weights   (weights),
        .biases    (biases),
        .pixel_out (pixel_out),
        .done      (done)
    );

endmodule

// ==== verification/sr_conv_tb.sv ====
`timescale 1ns/100ps
`include "sr_conv_macros.svh"

module sr_conv_tb;
    import sr_conv_pkg::*;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int COEF_WORDS   = `SR_WEIGHTS + `SR_CHANNELS;
    localparam int OC_STRIDE    = `SR_CHANNELS * `SR_TAPS;
    localparam int MAX_CHAN     = (1 << `SR_CHAN_W) - 1;
    localparam int DONE_LAT     = `SR_STEPS + 1;     // Start edge to done edge
    localparam int BUSY_EDGES   = `SR_STEPS + 1;
    localparam logic [16:0] LFSR_SEED = 17'd91096;

    // Weight sources
    localparam logic [2:0] W_ZERO = 3'd0;
    localparam logic [2:0] W_POS  = 3'd1;
    localparam logic [2:0] W_NEG  = 3'd2;
    localparam logic [2:0] W_ONE  = 3'd3;            // Single 1 at one_addr
    localparam logic [2:0] W_LFSR = 3'd4;

    localparam logic [1:0] M_PLAIN   = 2'd0;
    localparam logic [1:0] M_RESTART = 2'd1;         // Extra start while busy
    localparam logic [1:0] M_BUSYWR  = 2'd2;         // Writes while busy, then a rerun

    typedef pixel_t [`SR_TAPS-1:0] window_t;

    typedef struct packed {
        logic [8*14-1:0] name;
        logic [2:0]      wsrc;
        coef_addr_t      one_addr;
        logic [3:0]      wbits;                      // LFSR bits per weight
        logic [3:0]      pbits;                      // LFSR bits per pixel channel
        coef_t [2:0]     bias;
        logic            pix_lfsr;
        window_t         win;
        pixel_t          exp_px;                     // Left at zero for LFSR rows
        logic [1:0]      mode;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  coef_we;
    coef_addr_t            coef_addr;
    coef_t                 coef_data;
    logic                  pix_we;
    logic [`SR_KPOS_W-1:0] pix_addr;
    pixel_t                pix_data;
    logic                  start;
    logic                  busy;
    logic                  done;
    pixel_t                pixel_out;

    row_t        rows [$];
    int          w_cur [`SR_WEIGHTS];
    int          b_cur [`SR_CHANNELS];
    pixel_t      win_cur [`SR_TAPS];
    pixel_t      exp_cur;
    logic [16:0] lfsr;
    int          cycle_cnt = 0;
    int          busy_edges = 0;
    int          done_seen = 0;
    int          timeout_limit = 0;

    sr_conv_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .pix_we    (pix_we),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .pixel_out (pixel_out)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Edge counter, sees busy and done as the DUT registers do
    always @(posedge clk) begin
        cycle_cnt++;
        if (busy) busy_edges++;
        if (done) done_seen++;
        if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", timeout_limit);
            abort_run();
        end
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int sign_ext(input int v, input int n);
        return (v >= (1 << (n - 1))) ? v - (1 << n) : v;
    endfunction

    function automatic pixel_t make_pixel(input int r, input int g, input int b);
        pixel_t p;
        p.r = r[7:0];
        p.g = g[7:0];
        p.b = b[7:0];
        return p;
    endfunction

    function automatic int chan_of(input pixel_t p, input int ic);
        if (ic == 0) return int'(p.r);
        else if (ic == 1) return int'(p.g);
        else return int'(p.b);
    endfunction

    function automatic window_t ramp_window();
        window_t w;
        for (int k = 0; k < `SR_TAPS; k++) begin
            w[k] = make_pixel('h10 + k, 'h20 + k, 'h30 + k);
        end
        return w;
    endfunction

    // Bias plus all 27 products, then limited to the pixel range
    function automatic pixel_t ref_pixel();
        int sum [`SR_CHANNELS];
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            sum[oc] = b_cur[oc];
            for (int ic = 0; ic < `SR_CHANNELS; ic++) begin
                for (int k = 0; k < `SR_TAPS; k++) begin
                    sum[oc] += chan_of(win_cur[k], ic) * w_cur[oc*OC_STRIDE + ic*`SR_TAPS + k];
                end
            end
            if (sum[oc] < 0) sum[oc] = 0;
            else if (sum[oc] > MAX_CHAN) sum[oc] = MAX_CHAN;
        end
        return make_pixel(sum[0], sum[1], sum[2]);
    endfunction

    task automatic add_row(input logic [8*14-1:0] name, input logic [2:0] wsrc, input int one_addr,
                           input int wbits, input int pbits, input int b0, input int b1,
                           input int b2, input logic pix_lfsr, input window_t win,
                           input pixel_t exp_px, input logic [1:0] mode);
        row_t r;
        r.name     = name;
        r.wsrc     = wsrc;
        r.one_addr = one_addr[6:0];
        r.wbits    = wbits[3:0];
        r.pbits    = pbits[3:0];
        r.bias[0]  = b0[7:0];
        r.bias[1]  = b1[7:0];
        r.bias[2]  = b2[7:0];
        r.pix_lfsr = pix_lfsr;
        r.win      = win;
        r.exp_px   = exp_px;
        r.mode     = mode;
        rows.push_back(r);
    endtask

    task automatic build_table();
        window_t ramp;
        window_t full;
        ramp = ramp_window();
        full = {`SR_TAPS{make_pixel(255, 255, 255)}};
        add_row("bias_only", W_ZERO, 0, 0, 0, 10, 20, 30, 0, ramp, make_pixel(10, 20, 30), M_PLAIN);
        add_row("sat_high", W_POS, 0, 0, 0, 0, 0, 0, 0, full, make_pixel(255, 255, 255), M_PLAIN);
        add_row("sat_low", W_NEG, 0, 0, 0, 0, 0, 0, 0, full, make_pixel(0, 0, 0), M_PLAIN);
        // Address oc*27 + ic*9 + k picks channel ic of pixel k into output oc
        add_row("map_o0_i0_k0", W_ONE, 0, 0, 0, 0, 0, 0, 0, ramp, make_pixel('h10, 0, 0), M_PLAIN);
        add_row("map_o1_i2_k4", W_ONE, 49, 0, 0, 0, 0, 0, 0, ramp, make_pixel(0, 'h34, 0), M_PLAIN);
        add_row("map_o2_i1_k8", W_ONE, 71, 0, 0, 0, 0, 0, 0, ramp, make_pixel(0, 0, 'h28), M_PLAIN);
        add_row("map_o0_i2_k5", W_ONE, 23, 0, 0, 0, 0, 0, 0, ramp, make_pixel('h35, 0, 0), M_PLAIN);
        add_row("map_o2_i0_k3", W_ONE, 57, 0, 0, 0, 0, 0, 0, ramp, make_pixel(0, 0, 'h13), M_PLAIN);
        add_row("rand_full", W_LFSR, 0, 8, 8, 0, 0, 0, 1, ramp, '0, M_PLAIN);
        add_row("rand_mid", W_LFSR, 0, 3, 4, 0, 0, 0, 1, ramp, '0, M_PLAIN);
        add_row("rand_small", W_LFSR, 0, 2, 5, 0, 0, 0, 1, ramp, '0, M_PLAIN);
        add_row("rand_mix", W_LFSR, 0, 4, 3, 0, 0, 0, 1, ramp, '0, M_PLAIN);
        add_row("second_start", W_LFSR, 0, 3, 4, 0, 0, 0, 1, ramp, '0, M_RESTART);
        add_row("busy_writes", W_LFSR, 0, 3, 4, 0, 0, 0, 1, ramp, '0, M_BUSYWR);
    endtask

    task automatic load_row(input row_t r);
        int v;
        int vg;
        int vb;
        for (int a = 0; a < `SR_WEIGHTS; a++) begin
            case (r.wsrc)
                W_ZERO:  w_cur[a] = 0;
                W_POS:   w_cur[a] = 127;
                W_NEG:   w_cur[a] = -128;
                W_ONE:   w_cur[a] = (a == int'(r.one_addr)) ? 1 : 0;
                default: begin
                    draw_bits(r.wbits, v);
                    w_cur[a] = sign_ext(v, r.wbits);
                end
            endcase
        end
        for (int oc = 0; oc < `SR_CHANNELS; oc++) begin
            if (r.wsrc == W_LFSR) begin
                draw_bits(`SR_CHAN_W, v);
                b_cur[oc] = sign_ext(v, `SR_CHAN_W);
            end else begin
                b_cur[oc] = $signed(r.bias[oc]);
            end
        end
        for (int k = 0; k < `SR_TAPS; k++) begin
            if (r.pix_lfsr) begin
                draw_bits(r.pbits, v);
                draw_bits(r.pbits, vg);
                draw_bits(r.pbits, vb);
                win_cur[k] = make_pixel(v, vg, vb);
            end else begin
                win_cur[k] = r.win[k];
            end
        end
        exp_cur = (r.wsrc == W_LFSR || r.pix_lfsr) ? ref_pixel() : r.exp_px;
    endtask

    task automatic write_coefs();
        for (int a = 0; a < COEF_WORDS; a++) begin
            @(negedge clk);
            coef_we   = 1'b1;
            coef_addr = a[6:0];
            coef_data = (a < `SR_WEIGHTS) ? w_cur[a][7:0] : b_cur[a - `SR_WEIGHTS][7:0];
        end
    endtask

    task automatic write_window();
        for (int k = 0; k < `SR_TAPS; k++) begin
            @(negedge clk);
            coef_we  = 1'b0;
            pix_we   = 1'b1;
            pix_addr = k[3:0];
            pix_data = win_cur[k];
        end
    endtask

    // Pulses start and waits for done, counting edges from the start edge
    task automatic run_conv(input logic [1:0] mode, output int lat, output int busy_n);
        int start_edge;
        int busy_base;
        int n;
        @(negedge clk);
        coef_we    = 1'b0;
        pix_we     = 1'b0;
        start      = 1'b1;
        start_edge = cycle_cnt + 1;
        busy_base  = busy_edges;
        @(negedge clk);
        start = 1'b0;
        n     = 0;
        while (!done) begin
            n++;
            start = (mode == M_RESTART) && (n == 5);
            if ((mode == M_BUSYWR) && (n == 10)) begin
                // Operands of the last tap, not yet consumed
                coef_we   = 1'b1;
                coef_addr = coef_addr_t'(`SR_WEIGHTS - 1);
                coef_data = w_cur[`SR_WEIGHTS-1][7:0] ^ 8'h55;
                pix_we    = 1'b1;
                pix_addr  = 4'(`SR_TAPS - 1);
                pix_data  = win_cur[`SR_TAPS-1] ^ 24'ha5a5a5;
            end else begin
                coef_we = 1'b0;
                pix_we  = 1'b0;
            end
            @(negedge clk);
        end
        lat    = cycle_cnt - start_edge;
        busy_n = busy_edges - busy_base;
    endtask

    task automatic check_count(input logic [8*14-1:0] name, input string what,
                               input int exp_val, input int act);
        assert (act == exp_val) else begin
            $display("FAILED %0s %0s: expected %0d, actual %0d", name, what, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_pixel(input logic [8*14-1:0] name, input pixel_t exp_val,
                               input pixel_t act);
        assert (act == exp_val) else begin
            $display("FAILED %0s pixel_out: expected %h, actual %h", name, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_run(input logic [8*14-1:0] name, input int lat, input int busy_n);
        check_pixel(name, exp_cur, pixel_out);
        check_count(name, "done latency", DONE_LAT, lat);
        check_count(name, "busy cycles", BUSY_EDGES, busy_n);
    endtask

    initial begin
        int lat;
        int busy_n;
        int done_base;
        int busy_base;
        clk       = 1'b0;
        rst_n     = 1'b0;
        coef_we   = 1'b0;
        coef_addr = '0;
        coef_data = '0;
        pix_we    = 1'b0;
        pix_addr  = '0;
        pix_data  = '0;
        start     = 1'b0;
        lfsr      = LFSR_SEED;
        build_table();
        timeout_limit = rows.size() * (COEF_WORDS + `SR_TAPS + 30) + 200;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_count("reset", "busy", 0, busy);
        check_count("reset", "done", 0, done);
        check_pixel("reset", '0, pixel_out);

        foreach (rows[i]) begin
            load_row(rows[i]);
            write_coefs();
            write_window();
            run_conv(rows[i].mode, lat, busy_n);
            check_run(rows[i].name, lat, busy_n);
            if (rows[i].mode == M_RESTART) begin
                done_base = done_seen;
                busy_base = busy_edges;
                repeat (`SR_STEPS + 5) @(negedge clk);
                check_count(rows[i].name, "done pulses", 1, done_seen - done_base);
                check_count(rows[i].name, "late busy", 0, busy_edges - busy_base);
            end else if (rows[i].mode == M_BUSYWR) begin
                // Stores must still hold the values from before the run
                run_conv(M_PLAIN, lat, busy_n);
                check_run(rows[i].name, lat, busy_n);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/sr_conv_pkg.sv
design/conv_sequencer.sv
design/kernel_store.sv
design/window_buffer.sv
design/mac_array.sv
design/sr_conv_top.sv
verification/sr_conv_tb.sv

// ==== Bender.yml ====
package:
  name: sr_conv

sources:
  - include_dirs:
      - design
    files:
      - design/sr_conv_pkg.sv
      - design/conv_sequencer.sv
      - design/kernel_store.sv
      - design/window_buffer.sv
      - design/mac_array.sv
      - design/sr_conv_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/sr_conv_tb.sv
